// File: build.f
switch_ctrl_pkg.sv
spi_link_if.sv
spi_front.sv
cmd_exec.sv
heartbeat.sv
switch_top.sv
switch_top_assert.sv
tb_switch_top.sv

// File: cmd_exec.sv
// command executor: free-running timestamp counter and switch latch driven by spi bytes
`timescale 1ns/1ps

module cmd_exec (
  input  logic      clk,
  input  logic      rst_n,
  spi_link_if.exec  link,
  output logic      m_short,
  output logic      led_switch
);

  import switch_ctrl_pkg::*;

  // timestamp, counts clk cycles since reset or the last clear
  ts_t  ts_cnt;

  // decoded one-cycle commands
  logic do_clear;
  logic do_close;
  logic do_open;

  // switch state, high means shorted
  logic switch_q;

  ////////////////////////////////////////////////////////////
  // command decode
  ////////////////////////////////////////////////////////////

  // a byte only counts in its rx_valid cycle
  assign do_clear = link.rx_valid && (link.rx_byte == CMD_CLEAR);
  assign do_close = link.rx_valid && (link.rx_byte == CMD_CLOSE);
  assign do_open  = link.rx_valid && (link.rx_byte == CMD_OPEN);

  // unknown bytes fall through all three compares

  ////////////////////////////////////////////////////////////
  // timestamp counter
  ////////////////////////////////////////////////////////////

  // clear loads zero in place of the increment
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      ts_cnt <= '0;
    else if (do_clear)
      ts_cnt <= '0;
    else
      ts_cnt <= ts_cnt + ts_t'(1);
  end

  // front end samples this at frame start
  assign link.tx_word = ts_cnt;

  ////////////////////////////////////////////////////////////
  // switch latch
  ////////////////////////////////////////////////////////////

  // close and open are exclusive byte values, priority never matters
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      switch_q <= 1'b0;
    else if (do_close)
      switch_q <= 1'b1;
    else if (do_open)
      switch_q <= 1'b0;
  end

  // led mirrors the switch drive from the same flop
  assign m_short    = switch_q;
  assign led_switch = switch_q;

endmodule

// File: heartbeat.sv
// heartbeat blinker: clock divider that toggles an led on every counter wrap
`timescale 1ns/1ps

module heartbeat #(
  parameter int HB_DIV_BITS = 22
) (
  input  logic clk,
  input  logic rst_n,
  output logic led_heartbeat
);

  // own divider, untouched by timestamp clears
  logic [HB_DIV_BITS-1:0] div_cnt;
  logic                   div_wrap;
  logic                   led_q;

  // last count before rollover
  assign div_wrap = &div_cnt;

  // led period is 2 * 2**HB_DIV_BITS clk cycles
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      div_cnt <= '0;
      led_q   <= 1'b0;
    end
    else
    begin
      div_cnt <= div_cnt + 1'b1;
      if (div_wrap)
        led_q <= ~led_q;
    end
  end

  assign led_heartbeat = led_q;

endmodule

// File: spi_front.sv
// spi mode 0 slave front end: pin synchronizers, byte receiver and miso readout shifter
`timescale 1ns/1ps

module spi_front (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       sck,
  input  logic       ssel,
  input  logic       mosi,
  output logic       miso,
  spi_link_if.front  link
);

  import switch_ctrl_pkg::*;

  localparam int CNT_W = $clog2(BYTE_W);
  localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(BYTE_W - 1);

  // synchronizer chains, top bit is the edge-detect delay flop
  logic [SYNC_LAT:0] sck_s;
  logic [SYNC_LAT:0] ssel_s;
  logic [SYNC_LAT:0] mosi_s;

  // registered edge strobes
  logic              sck_rise;
  logic              sck_fall;
  logic              ssel_start;

  logic              ssel_active;
  logic              mosi_bit;

  // byte receiver
  logic [CNT_W-1:0]  bit_cnt;
  logic [BYTE_W-1:0] rx_shift;
  logic              rx_valid_q;

  // readout shifter
  ts_t               tx_shift;

  ////////////////////////////////////////////////////////////
  // input synchronization
  ////////////////////////////////////////////////////////////

  // sck idles low in mode 0, ssel idles high
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sck_s  <= '0;
      ssel_s <= '1;
    end
    else
    begin
      sck_s  <= {sck_s[SYNC_LAT-1:0], sck};
      ssel_s <= {ssel_s[SYNC_LAT-1:0], ssel};
    end
  end

  // mosi runs through the same depth so it lines up with the sck strobes
  always_ff @(posedge clk)
  begin
    mosi_s <= {mosi_s[SYNC_LAT-1:0], mosi};
  end

  // edge detect stage, one cycle behind the synchronizer
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sck_rise   <= 1'b0;
      sck_fall   <= 1'b0;
      ssel_start <= 1'b0;
    end
    else
    begin
      sck_rise   <= sck_s[SYNC_LAT-1] & ~sck_s[SYNC_LAT];
      sck_fall   <= ~sck_s[SYNC_LAT-1] & sck_s[SYNC_LAT];
      ssel_start <= ~ssel_s[SYNC_LAT-1] & ssel_s[SYNC_LAT];
    end
  end

  // delay flops already hold the new level when a strobe fires
  assign ssel_active = ~ssel_s[SYNC_LAT];
  assign mosi_bit    = mosi_s[SYNC_LAT];

  ////////////////////////////////////////////////////////////
  // byte receiver
  ////////////////////////////////////////////////////////////

  // held at zero outside a frame, so a partial byte is dropped
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      bit_cnt <= '0;
    else if (!ssel_active)
      bit_cnt <= '0;
    else if (sck_rise)
      bit_cnt <= bit_cnt + 1'b1;
  end

  // shift left, msb arrives first
  always_ff @(posedge clk)
  begin
    if (ssel_active && sck_rise)
      rx_shift <= {rx_shift[BYTE_W-2:0], mosi_bit};
  end

  // pulse one cycle after the last bit of a byte
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      rx_valid_q <= 1'b0;
    else
      rx_valid_q <= ssel_active && sck_rise && (bit_cnt == LAST_BIT);
  end

  ////////////////////////////////////////////////////////////
  // timestamp readout
  ////////////////////////////////////////////////////////////

  // load at frame start, then one bit per falling sck; zeros fill from the right
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      tx_shift <= '0;
    else if (ssel_start)
      tx_shift <= link.tx_word;
    else if (ssel_active && sck_fall)
      tx_shift <= {tx_shift[TS_W-2:0], 1'b0};
  end

  // single slave on the bus, miso is always driven
  assign miso = tx_shift[TS_W-1];

  assign link.rx_valid    = rx_valid_q;
  assign link.rx_byte     = rx_shift;
  assign link.frame_start = ssel_start;

endmodule

// File: spi_link_if.sv
// byte and readout link between the spi front end and the command executor
`timescale 1ns/1ps

interface spi_link_if;

  import switch_ctrl_pkg::*;

  // one-cycle strobe, a full byte has been shifted in
  logic              rx_valid;

  // received byte, only meaningful while rx_valid is high
  logic [BYTE_W-1:0] rx_byte;

  // one-cycle strobe on the synchronized falling edge of ssel
  logic              frame_start;

  // live timestamp, sampled by the front end at frame start
  ts_t               tx_word;

  // spi side: produces bytes and frame starts, consumes the readout word
  modport front (
    output rx_valid,
    output rx_byte,
    output frame_start,
    input  tx_word
  );

  // executor side: consumes bytes, provides the readout word
  modport exec (
    input  rx_valid,
    input  rx_byte,
    input  frame_start,
    output tx_word
  );

endinterface

// File: switch_ctrl_pkg.sv
// analog switch controller shared definitions: command bytes, widths and timestamp type
package switch_ctrl_pkg;

  ////////////////////////////////////////////////////////////
  // spi framing
  ////////////////////////////////////////////////////////////

  // one spi transfer unit, sent msb first
  localparam int BYTE_W = 8;

  // width of the free-running timestamp and of the miso readout word
  localparam int TS_W = 32;

  // pin change to edge strobe, counted in synchronizer flops
  // the registered edge stage adds one more cycle on top
  localparam int SYNC_LAT = 2;

  ////////////////////////////////////////////////////////////
  // command bytes
  ////////////////////////////////////////////////////////////

  // zero the timestamp counter
  localparam logic [BYTE_W-1:0] CMD_CLEAR = 8'hCC;

  // close the switch, shorting the measuring capacitor
  localparam logic [BYTE_W-1:0] CMD_CLOSE = 8'hCD;

  // open the switch again
  localparam logic [BYTE_W-1:0] CMD_OPEN = 8'hCE;

  // every other byte value is a no-op

  ////////////////////////////////////////////////////////////
  // types
  ////////////////////////////////////////////////////////////

  // timestamp, also the word shifted out on miso
  typedef logic [TS_W-1:0] ts_t;

endpackage

// File: switch_top.sv
// analog switch controller top: spi slave front end, command executor and heartbeat led
`timescale 1ns/1ps

module switch_top #(
  parameter int HB_DIV_BITS = 22
) (
  input  logic clk,
  input  logic rst_n,

  // spi mode 0 slave pins
  input  logic sck,
  input  logic ssel,
  input  logic mosi,
  output logic miso,

  // switch drive, high shorts the capacitor
  output logic m_short,

  // status leds
  output logic led_switch,
  output logic led_heartbeat
);

  ////////////////////////////////////////////////////////////
  // spi byte and readout link
  ////////////////////////////////////////////////////////////

  spi_link_if u_link ();

  // pins in, bytes and frame starts out
  spi_front u_front (
    .clk   (clk),
    .rst_n (rst_n),
    .sck   (sck),
    .ssel  (ssel),
    .mosi  (mosi),
    .miso  (miso),
    .link  (u_link)
  );

  // bytes in, timestamp and switch state out
  cmd_exec u_exec (
    .clk        (clk),
    .rst_n      (rst_n),
    .link       (u_link),
    .m_short    (m_short),
    .led_switch (led_switch)
  );

  ////////////////////////////////////////////////////////////
  // heartbeat
  ////////////////////////////////////////////////////////////

  // divider width comes from the top parameter
  heartbeat #(
    .HB_DIV_BITS (HB_DIV_BITS)
  ) u_heartbeat (
    .clk           (clk),
    .rst_n         (rst_n),
    .led_heartbeat (led_heartbeat)
  );

endmodule

// File: switch_top_assert.sv
// bound checker for switch state, readout timing and heartbeat period of the switch controller
`timescale 1ns/1ps

module switch_top_assert (
  input logic clk,
  input logic rst_n,
  input logic sck,
  input logic ssel,
  input logic mosi,
  input logic miso,
  input logic m_short,
  input logic led_switch,
  input logic led_heartbeat
);

  import switch_ctrl_pkg::*;

  int fail_cnt = 0;

  // pin-level spi model
  logic        sck_q;
  logic        ssel_q;
  logic [2:0]  bit_cnt;
  logic [7:0]  byte_sh;
  ts_t         rd_sh;
  int unsigned rise_cnt;
  logic        exp_sw;
  logic [2:0]  settle;

  // readout bookkeeping with cycle numbers taken at the pin edges
  ts_t  cyc;
  ts_t  fall_cyc;
  ts_t  prev_fall;
  ts_t  clear_cyc;
  ts_t  prev_rd;
  ts_t  delta;
  ts_t  elapsed;
  ts_t  since_clear;
  logic ref_valid;
  logic after_clear;
  logic clear_in_frame;
  logic snap_valid;
  logic snap_after;
  logic chk_grow;
  logic chk_clear;

  // heartbeat
  logic        hb_prev;
  logic        hb_seen;
  int unsigned hb_age;

  wire       sck_up    = sck & ~sck_q;
  wire       ssel_dn   = ~ssel & ssel_q;
  wire       ssel_up   = ssel & ~ssel_q;
  wire [7:0] next_byte = {byte_sh[6:0], mosi};
  wire       byte_done = !ssel && sck_up && (bit_cnt == 3'd7);

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cyc            <= '0;
      sck_q          <= 1'b0;
      ssel_q         <= 1'b1;
      bit_cnt        <= '0;
      rise_cnt       <= 0;
      exp_sw         <= 1'b0;
      settle         <= '0;
      ref_valid      <= 1'b0;
      after_clear    <= 1'b0;
      clear_in_frame <= 1'b0;
      chk_grow       <= 1'b0;
      chk_clear      <= 1'b0;
    end
    else
    begin
      cyc      <= cyc + 1;
      sck_q    <= sck;
      ssel_q   <= ssel;
      chk_grow <= 1'b0;
      chk_clear <= 1'b0;
      if (settle != 0)
        settle <= settle - 1'b1;
      if (ssel)
        bit_cnt <= '0;
      else if (sck_up)
      begin
        bit_cnt  <= bit_cnt + 1'b1;
        byte_sh  <= next_byte;
        rd_sh    <= {rd_sh[TS_W-2:0], miso};
        rise_cnt <= rise_cnt + 1;
      end
      // synchronizer, then strobe, rx_valid and the latch itself
      if (byte_done)
      begin
        settle <= 3'(SYNC_LAT + 2);
        if (next_byte == CMD_CLOSE)
          exp_sw <= 1'b1;
        else if (next_byte == CMD_OPEN)
          exp_sw <= 1'b0;
        else if (next_byte == CMD_CLEAR)
        begin
          clear_cyc      <= cyc;
          after_clear    <= 1'b1;
          ref_valid      <= 1'b0;
          clear_in_frame <= 1'b1;
        end
      end
      if (ssel_dn)
      begin
        fall_cyc       <= cyc;
        rise_cnt       <= 0;
        snap_valid     <= ref_valid;
        snap_after     <= after_clear;
        clear_in_frame <= 1'b0;
      end
      // only full 32-bit frames carry a whole readout
      if (ssel_up && rise_cnt == TS_W)
      begin
        prev_rd     <= rd_sh;
        prev_fall   <= fall_cyc;
        delta       <= rd_sh - prev_rd;
        elapsed     <= fall_cyc - prev_fall;
        since_clear <= fall_cyc - clear_cyc;
        chk_grow    <= snap_valid;
        chk_clear   <= snap_after && !snap_valid;
        if (!clear_in_frame)
        begin
          ref_valid   <= 1'b1;
          after_clear <= 1'b0;
        end
      end
    end
  end

  // cycles since the last heartbeat toggle
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      hb_prev <= 1'b0;
      hb_seen <= 1'b0;
      hb_age  <= 0;
    end
    else
    begin
      hb_prev <= led_heartbeat;
      if (led_heartbeat != hb_prev)
      begin
        hb_seen <= 1'b1;
        hb_age  <= 0;
      end
      else
        hb_age <= hb_age + 1;
    end
  end

  ////////////////////////////////////////////////////////////
  // assertions
  ////////////////////////////////////////////////////////////

  a_reset: assert property (@(posedge clk)
    !rst_n |-> (!m_short && !led_switch && !led_heartbeat && !miso))
    else begin
      $error("ERR %0t {m_short,led_switch,led_heartbeat,miso} expected 0000 actual %b%b%b%b",
        $time, $sampled(m_short), $sampled(led_switch), $sampled(led_heartbeat),
        $sampled(miso));
      fail_cnt++;
    end

  a_release: assert property (@(posedge clk)
    $rose(rst_n) |-> (!m_short && !led_switch && !led_heartbeat && !miso))
    else begin
      $error("ERR %0t {m_short,led_switch,led_heartbeat,miso} expected 0000 actual %b%b%b%b",
        $time, $sampled(m_short), $sampled(led_switch), $sampled(led_heartbeat),
        $sampled(miso));
      fail_cnt++;
    end

  // covers close, open, noise bytes and aborted bytes
  a_switch: assert property (@(posedge clk) disable iff (!rst_n)
    (settle == 0) |-> (m_short == exp_sw))
    else begin
      $error("ERR %0t m_short expected %b actual %b", $time, $sampled(exp_sw),
        $sampled(m_short));
      fail_cnt++;
    end

  a_mirror: assert property (@(posedge clk) disable iff (!rst_n) m_short == led_switch)
    else begin
      $error("ERR %0t led_switch expected %b actual %b", $time, $sampled(m_short),
        $sampled(led_switch));
      fail_cnt++;
    end

  a_growth: assert property (@(posedge clk) disable iff (!rst_n)
    chk_grow |-> ((delta + 1 >= elapsed) && (delta <= elapsed + 1)))
    else begin
      $error("ERR %0t readout growth expected %0d actual %0d", $time, $sampled(elapsed),
        $sampled(delta));
      fail_cnt++;
    end

  a_clear: assert property (@(posedge clk) disable iff (!rst_n)
    chk_clear |-> (prev_rd <= since_clear + 3))
    else begin
      $error("ERR %0t readout after clear expected <= %0d actual %0d", $time,
        $sampled(since_clear) + 3, $sampled(prev_rd));
      fail_cnt++;
    end

  // toggles exactly 16 cycles apart
  a_hb_period: assert property (@(posedge clk) disable iff (!rst_n)
    (hb_seen && led_heartbeat != hb_prev) |-> (hb_age == 15))
    else begin
      $error("ERR %0t led_heartbeat period expected 16 actual %0d", $time,
        $sampled(hb_age) + 1);
      fail_cnt++;
    end

  // the first wait after reset release peaks at 16
  a_hb_stuck: assert property (@(posedge clk) disable iff (!rst_n)
    hb_age <= 16)
    else begin $error("heartbeat stopped toggling"); fail_cnt++; end

endmodule

bind switch_top switch_top_assert u_assert (.*);

// File: tb_switch_top.sv
// testbench for the analog switch controller with spi master model, commands and run control
`timescale 1ns/1ps

module tb_switch_top;

  import switch_ctrl_pkg::*;

  // short divider so the heartbeat toggles often
  localparam int HB_BITS = 4;

  // half an sck period in clk cycles
  localparam int HALF = 4;

  // number of frames sent below, none longer than 32 bits
  localparam int N_FRAMES = 16;

  // worst-case frame is 32 bits of two halves plus select setup and gap
  localparam int FRAME_CYC = 32 * 2 * HALF + 4 * HALF;
  localparam int WD_CYCLES = N_FRAMES * FRAME_CYC + 400;

  logic clk;
  logic rst_n;
  logic sck;
  logic ssel;
  logic mosi;
  logic miso;
  logic m_short;
  logic led_switch;
  logic led_heartbeat;

  ////////////////////////////////////////////////////////////
  // dut and clock
  ////////////////////////////////////////////////////////////

  switch_top #(
    .HB_DIV_BITS (HB_BITS)
  ) u_switch_top (
    .clk           (clk),
    .rst_n         (rst_n),
    .sck           (sck),
    .ssel          (ssel),
    .mosi          (mosi),
    .miso          (miso),
    .m_short       (m_short),
    .led_switch    (led_switch),
    .led_heartbeat (led_heartbeat)
  );

  // 20 ns period
  always #10 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  // random byte that is none of the three commands
  function automatic logic [7:0] pick_noise_byte();
    logic [7:0] b;
    b = 8'($urandom);
    if (b == CMD_CLEAR || b == CMD_CLOSE || b == CMD_OPEN)
      b = 8'h5A;
    return b;
  endfunction

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  // one mode 0 frame; nbits may cut the last byte short
  task automatic spi_frame(input logic [7:0] bytes[$], input int nbits, output ts_t rd);
    int i;
    logic [7:0] cur;
    rd = '0;
    @(negedge clk);
    ssel = 1'b0;
    for (i = 0; i < nbits; i++)
    begin
      cur  = bytes[i / 8];
      mosi = cur[7 - (i % 8)];
      wait_cycles(HALF);
      sck = 1'b1;
      // miso only moves on posedge clk and is stable here
      rd = {rd[TS_W-2:0], miso};
      wait_cycles(HALF);
      sck = 1'b0;
    end
    wait_cycles(HALF);
    ssel = 1'b1;
    mosi = 1'b0;
    wait_cycles(2 * HALF);
  endtask

  // one command byte in a frame of its own
  task automatic send_cmd(input logic [7:0] b);
    logic [7:0] q[$];
    ts_t rd;
    q = {b};
    spi_frame(q, 8, rd);
  endtask

  // full 32-bit frame so the whole timestamp comes back
  task automatic read_frame(input logic [7:0] b0);
    logic [7:0] q[$];
    ts_t rd;
    q = {b0, pick_noise_byte(), pick_noise_byte(), pick_noise_byte()};
    spi_frame(q, 32, rd);
  endtask

  ////////////////////////////////////////////////////////////
  // fail path and watchdog
  ////////////////////////////////////////////////////////////

  // the bound checker counts failed assertions
  always @(negedge clk)
  begin
    if (u_switch_top.u_assert.fail_cnt != 0)
    begin
      $display("Something failed");
      $fatal(1, "an assertion in the bound checker fired");
    end
  end

  initial
  begin
    repeat (WD_CYCLES) @(posedge clk);
    $display("Something failed");
    $fatal(1, "watchdog expired before the stimulus finished");
  end

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////

  initial
  begin
    logic [7:0] q[$];
    ts_t rd;
    void'($urandom(32'h0d03c8a3));
    clk      = 1'b0;
    rst_n    = 1'b1;
    sck      = 1'b0;
    ssel     = 1'b1;
    mosi     = 1'b0;
    // clean falling edge on reset
    #1 rst_n = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    wait_cycles(10);

    // single-byte commands and noise
    send_cmd(CMD_CLOSE);
    send_cmd(CMD_OPEN);
    send_cmd(pick_noise_byte());
    send_cmd(CMD_CLOSE);
    send_cmd(pick_noise_byte());
    send_cmd(pick_noise_byte());

    // aborted open after 5 bits leaves the switch closed
    q = {CMD_OPEN};
    spi_frame(q, 5, rd);

    // multi-byte frames that each give a readout
    read_frame(CMD_OPEN);
    read_frame(pick_noise_byte());
    read_frame(CMD_CLOSE);

    // clear then readouts near zero and growing again
    send_cmd(CMD_CLEAR);
    read_frame(pick_noise_byte());
    read_frame(CMD_OPEN);

    // clear in the middle of a readout frame
    q = {pick_noise_byte(), CMD_CLEAR, pick_noise_byte(), pick_noise_byte()};
    spi_frame(q, 32, rd);
    read_frame(pick_noise_byte());
    read_frame(pick_noise_byte());

    wait_cycles(40);
    if (u_switch_top.u_assert.fail_cnt == 0)
    begin
      $display("Everything OK");
      $finish;
    end
    else
    begin
      $display("Something failed");
      $fatal(1, "assertion failures at end of run");
    end
  end

endmodule
